// ==== sgmii_pkg.sv ====
// SGMII 8b/10b receive decoder
// Shared types and constants
package sgmii_pkg;

        // --------------------
        // Widths

        localparam int CODE_GROUP_W = 10;
        localparam int OCTET_W      = 8;
        localparam int RD_W         = 5;

        // --------------------
        // Code group and byte types

        typedef logic [CODE_GROUP_W-1:0] code_group_t;  // Bit 9 is a, bit 0 is j
        typedef logic [5:0]              sub6_t;        // abcdei
        typedef logic [3:0]              sub4_t;        // fghj
        typedef logic [OCTET_W-1:0]      octet_t;       // HGFEDCBA, H in bit 7

        // Any word outside the code is reported as control with this byte
        localparam octet_t INVALID_OCTET = 8'h00;

        // Verdict of the 6b sub-block lookup
        typedef enum logic [1:0]
        {
                SUB_DATA,
                SUB_K28,
                SUB_INVALID
        } sub_kind_e;

        // --------------------
        // Running disparity

        typedef logic [RD_W-1:0] rd_count_t;

        // Midpoint of the sum, so it can drift by 7 either way before the top bit sets
        localparam rd_count_t RD_INIT = 5'd8;

        localparam rd_count_t BALANCE_ONES = 5'd5;  // Ones in a balanced code group

endpackage

// ==== decode_6b5b.sv ====
// 5b/6b sub-block decoder
`timescale 1ns/100ps

module decode_6b5b
(
        input  sgmii_pkg::sub6_t     sub6,
        output logic [4:0]           edcba,
        output sgmii_pkg::sub_kind_e kind
);
        import sgmii_pkg::*;

        // Both running disparity columns decode to the same value
        always_comb
        begin
                edcba = 5'd0;
                kind  = SUB_DATA;

                case (sub6)
                // --------------------
                // D.0 to D.15
                6'b100111, 6'b011000: edcba = 5'd0;
                6'b011101, 6'b100010: edcba = 5'd1;
                6'b101101, 6'b010010: edcba = 5'd2;
                6'b110001:            edcba = 5'd3;
                6'b110101, 6'b001010: edcba = 5'd4;
                6'b101001:            edcba = 5'd5;
                6'b011001:            edcba = 5'd6;
                6'b111000, 6'b000111: edcba = 5'd7;   // Balanced but still has two forms
                6'b111001, 6'b000110: edcba = 5'd8;
                6'b100101:            edcba = 5'd9;
                6'b010101:            edcba = 5'd10;
                6'b110100:            edcba = 5'd11;
                6'b001101:            edcba = 5'd12;
                6'b101100:            edcba = 5'd13;
                6'b011100:            edcba = 5'd14;
                6'b010111, 6'b101000: edcba = 5'd15;

                // --------------------
                // D.16 to D.31
                6'b011011, 6'b100100: edcba = 5'd16;
                6'b100011:            edcba = 5'd17;
                6'b010011:            edcba = 5'd18;
                6'b110010:            edcba = 5'd19;
                6'b001011:            edcba = 5'd20;
                6'b101010:            edcba = 5'd21;
                6'b011010:            edcba = 5'd22;
                6'b111010, 6'b000101: edcba = 5'd23;
                6'b110011, 6'b001100: edcba = 5'd24;
                6'b100110:            edcba = 5'd25;
                6'b010110:            edcba = 5'd26;
                6'b110110, 6'b001001: edcba = 5'd27;
                6'b001110:            edcba = 5'd28;  // D.28 only, K.28 is below
                6'b101110, 6'b010001: edcba = 5'd29;
                6'b011110, 6'b100001: edcba = 5'd30;
                6'b101011, 6'b010100: edcba = 5'd31;

                // --------------------
                // Control and unused patterns
                6'b001111, 6'b110000:
                begin
                        edcba = 5'd28;
                        kind  = SUB_K28;
                end

                default:
                begin
                        kind = SUB_INVALID;
                end
                endcase
        end

endmodule

// ==== decode_4b3b.sv ====
// 3b/4b sub-block decoder
`timescale 1ns/100ps

module decode_4b3b
(
        input  sgmii_pkg::sub4_t sub4,
        input  logic             k28_inverted,
        output logic [2:0]       hgf,
        output logic             alt7,
        output logic             invalid
);
        import sgmii_pkg::*;

        sub4_t fghj;
        logic  balanced;

        // After 110000 the balanced K28 codes are sent complemented
        assign balanced = (sub4 == 4'b1001) || (sub4 == 4'b0110) ||
                          (sub4 == 4'b1010) || (sub4 == 4'b0101);
        assign fghj     = (k28_inverted && balanced) ? ~sub4 : sub4;

        always_comb
        begin
                hgf     = 3'd0;
                alt7    = 1'b0;
                invalid = 1'b0;

                case (fghj)
                4'b1011, 4'b0100: hgf = 3'd0;
                4'b1001:          hgf = 3'd1;
                4'b0101:          hgf = 3'd2;
                4'b1100, 4'b0011: hgf = 3'd3;
                4'b1101, 4'b0010: hgf = 3'd4;
                4'b1010:          hgf = 3'd5;
                4'b0110:          hgf = 3'd6;
                4'b1110, 4'b0001: hgf = 3'd7;   // Primary D.x.7
                4'b0111, 4'b1000:
                begin
                        hgf  = 3'd7;
                        alt7 = 1'b1;
                end
                default:
                begin
                        invalid = 1'b1;                 // All zeros or all ones
                end
                endcase
        end

endmodule

// ==== code_group_decoder.sv ====
// Code group delay line and byte decode
`timescale 1ns/100ps

module code_group_decoder
#(
        parameter int INPUT_STAGES = 3
)
(
        input  logic                   clk,
        input  sgmii_pkg::code_group_t ten_bit,
        output sgmii_pkg::code_group_t aligned_group,
        output sgmii_pkg::octet_t      eight_bit,
        output logic                   is_k
);
        import sgmii_pkg::*;

        code_group_t delay_q [INPUT_STAGES];
        sub6_t       sub6;
        sub4_t       sub4;
        logic [4:0]  edcba;
        logic [2:0]  hgf;
        sub_kind_e   kind;
        logic        alt7;
        logic        invalid4;
        logic        bad;
        octet_t      next_octet;
        logic        next_k;

        // --------------------
        // Input delay line

        always_ff @(posedge clk)
        begin
                delay_q[0] <= ten_bit;
                for (int i = 1; i < INPUT_STAGES; i++)
                begin
                        delay_q[i] <= delay_q[i-1];
                end
        end

        assign aligned_group = delay_q[INPUT_STAGES-1];
        assign sub6          = aligned_group[9:4];
        assign sub4          = aligned_group[3:0];

        decode_6b5b decode_6b5b_inst
        (
                .sub6   (sub6),
                .edcba  (edcba),
                .kind   (kind)
        );

        decode_4b3b decode_4b3b_inst
        (
                .sub4           (sub4),
                .k28_inverted   (sub6 == 6'b110000),    // RD+ form of K.28
                .hgf            (hgf),
                .alt7           (alt7),
                .invalid        (invalid4)
        );

        // --------------------
        // Control and data combining

        always_comb
        begin
                bad        = 1'b0;
                next_k     = 1'b0;
                next_octet = {hgf, edcba};

                if (kind == SUB_INVALID || invalid4)
                begin
                        bad = 1'b1;
                end
                else if (kind == SUB_K28)
                begin
                        next_k = 1'b1;
                end
                else if (alt7)
                begin
                        case (edcba)
                        5'd23, 5'd27, 5'd29, 5'd30:             next_k = 1'b1;
                        5'd11, 5'd13, 5'd14, 5'd17, 5'd18, 5'd20: next_k = 1'b0;
                        default:                                bad    = 1'b1;
                        endcase
                end

                if (bad)
                begin
                        next_octet = INVALID_OCTET;
                        next_k     = 1'b1;
                end
        end

        always_ff @(posedge clk)
        begin
                eight_bit <= next_octet;
                is_k      <= next_k;
        end

endmodule

// ==== running_disparity_monitor.sv ====
// Running disparity monitor
`timescale 1ns/100ps

module running_disparity_monitor
(
        input  logic                   clk,
        input  logic                   rst,
        input  logic                   sgmii_autoneg_start,
        input  sgmii_pkg::code_group_t aligned_group,
        output logic                   disp_err
);
        import sgmii_pkg::*;

        rd_count_t ones;
        rd_count_t rd_sum;

        always_comb
        begin
                ones = '0;
                for (int i = 0; i < CODE_GROUP_W; i++)
                begin
                        ones = ones + rd_count_t'(aligned_group[i]);
                end
        end

        always_ff @(posedge clk or posedge rst)
        begin
                if (rst)
                begin
                        rd_sum   <= RD_INIT;
                        disp_err <= 1'b0;
                end
                else if (!sgmii_autoneg_start)
                begin
                        rd_sum   <= RD_INIT;       // Held cleared until autoneg starts
                        disp_err <= 1'b0;
                end
                else
                begin
                        rd_sum   <= rd_sum + ones - BALANCE_ONES;  // Wraps in RD_W bits
                        disp_err <= disp_err | rd_sum[RD_W-1];    // Sum has left 0..15
                end
        end

endmodule

// ==== sgmii_8b10b_decode.sv ====
// SGMII 8b/10b receive decoder
`timescale 1ns/100ps

module sgmii_8b10b_decode
#(
        parameter int INPUT_STAGES = 3
)
(
        input  logic                   clk,
        input  logic                   rst,

        input  logic                   sgmii_autoneg_start,

        input  sgmii_pkg::code_group_t ten_bit,

        output sgmii_pkg::octet_t      eight_bit,
        output logic                   is_k,
        output logic                   disp_err
);
        import sgmii_pkg::*;

        code_group_t aligned_group;  // Code group at the end of the delay line

        code_group_decoder
        #(
                .INPUT_STAGES   (INPUT_STAGES)
        )
        code_group_decoder_inst
        (
                .clk            (clk),
                .ten_bit        (ten_bit),
                .aligned_group  (aligned_group),
                .eight_bit      (eight_bit),
                .is_k           (is_k)
        );

        running_disparity_monitor running_disparity_monitor_inst
        (
                .clk                    (clk),
                .rst                    (rst),
                .sgmii_autoneg_start    (sgmii_autoneg_start),
                .aligned_group          (aligned_group),
                .disp_err               (disp_err)
        );

endmodule

// ==== sgmii_decode_asserts.sv ====
// Disparity monitor assertions
`timescale 1ns/100ps

module sgmii_decode_asserts
(
        input logic clk,
        input logic rst,
        input logic sgmii_autoneg_start,
        input logic disp_err
);
        int assert_failures = 0;

        // Sticky while the monitor runs
        err_sticky: assert property (@(posedge clk) disable iff (rst)
                (!$past(rst) && $past(sgmii_autoneg_start) && $past(disp_err)) |-> disp_err)
        else
        begin
                assert_failures++;
                $error("disp_err fell while autoneg was running");
        end

        err_cleared: assert property (@(posedge clk) !sgmii_autoneg_start |=> !disp_err)
        else
        begin
                assert_failures++;
                $error("disp_err not cleared one cycle after autoneg went low");
        end

        err_after_reset: assert property (@(posedge clk) rst |=> !disp_err)
        else
        begin
                assert_failures++;
                $error("disp_err high on the first edge after reset");
        end

endmodule

bind running_disparity_monitor sgmii_decode_asserts sgmii_decode_asserts_inst
(
        .clk                    (clk),
        .rst                    (rst),
        .sgmii_autoneg_start    (sgmii_autoneg_start),
        .disp_err               (disp_err)
);

// ==== sgmii_decode_tb.sv ====
// SGMII 8b/10b decoder testbench
`timescale 1ns/100ps

module sgmii_decode_tb;
        import sgmii_pkg::*;

        localparam int INPUT_STAGES = 3;
        localparam int LATENCY      = INPUT_STAGES + 1;  // Table row to visible output
        localparam int RESET_CYCLES = 10;
        localparam int NUM_ROWS     = 75;
        localparam int SET_CYCLES   = 14;
        localparam int RESET_HOLD   = 2;
        localparam int RELEASE      = LATENCY + 2;
        localparam int TAIL_CYCLES  = SET_CYCLES + RESET_HOLD + RELEASE;
        localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS + TAIL_CYCLES + LATENCY + 20;

        localparam code_group_t FILLER  = 10'b101010_1010;  // D21.5, five ones
        localparam code_group_t K28_5_N = 10'b001111_1010;  // K28.5 RD-, six ones

        typedef struct packed
        {
                code_group_t word;
                octet_t      oct;
                logic        k;
                logic        an;     // sgmii_autoneg_start for this row
        } row_t;

        typedef struct packed
        {
                code_group_t word;
                octet_t      oct;
                logic        k;
                logic        chk;
        } flight_t;

        logic        clk;
        logic        rst;
        logic        sgmii_autoneg_start;
        code_group_t ten_bit;
        octet_t      eight_bit;
        logic        is_k;
        logic        disp_err;

        flight_t     flight_q [$];
        rd_count_t   model_sum;
        logic        model_err;
        logic        prev_an;
        logic        prev_rst;
        int          errors      = 0;
        int          checks      = 0;
        int          err_cycles  = 0;
        int          cycle_count = 0;
        int          assert_fails;

        // --------------------
        // Stimulus table, code group abcdei_fghj

        row_t stim [NUM_ROWS] = '{
                // Data, both columns
                {10'b100111_0100, 8'h00, 1'b0, 1'b0}, {10'b011000_1011, 8'h00, 1'b0, 1'b0},
                {10'b011101_1001, 8'h21, 1'b0, 1'b0}, {10'b010010_0101, 8'h42, 1'b0, 1'b0},
                {10'b110001_1100, 8'h63, 1'b0, 1'b0}, {10'b001010_1101, 8'h84, 1'b0, 1'b0},
                {10'b101001_1010, 8'ha5, 1'b0, 1'b0}, {10'b011001_0110, 8'hc6, 1'b0, 1'b0},
                {10'b111000_1110, 8'he7, 1'b0, 1'b0}, {10'b000111_0001, 8'he7, 1'b0, 1'b0},
                {10'b010101_0101, 8'h4a, 1'b0, 1'b0}, {10'b101000_1011, 8'h0f, 1'b0, 1'b0},
                {10'b011011_0101, 8'h50, 1'b0, 1'b0}, {10'b001100_0011, 8'h78, 1'b0, 1'b0},
                {10'b001110_1001, 8'h3c, 1'b0, 1'b0}, {10'b101011_0010, 8'h9f, 1'b0, 1'b0},
                {10'b100011_0111, 8'hf1, 1'b0, 1'b0}, {10'b110100_1000, 8'heb, 1'b0, 1'b0},
                // K28.0 to K28.7, RD- then RD+
                {10'b001111_0100, 8'h1c, 1'b1, 1'b0}, {10'b001111_1001, 8'h3c, 1'b1, 1'b0},
                {10'b001111_0101, 8'h5c, 1'b1, 1'b0}, {10'b001111_0011, 8'h7c, 1'b1, 1'b0},
                {10'b001111_0010, 8'h9c, 1'b1, 1'b0}, {10'b001111_1010, 8'hbc, 1'b1, 1'b0},
                {10'b001111_0110, 8'hdc, 1'b1, 1'b0}, {10'b001111_1000, 8'hfc, 1'b1, 1'b0},
                {10'b110000_1011, 8'h1c, 1'b1, 1'b0}, {10'b110000_0110, 8'h3c, 1'b1, 1'b0},
                {10'b110000_1010, 8'h5c, 1'b1, 1'b0}, {10'b110000_1100, 8'h7c, 1'b1, 1'b0},
                {10'b110000_1101, 8'h9c, 1'b1, 1'b0}, {10'b110000_0101, 8'hbc, 1'b1, 1'b0},
                {10'b110000_1001, 8'hdc, 1'b1, 1'b0}, {10'b110000_0111, 8'hfc, 1'b1, 1'b0},
                // K23.7, K27.7, K29.7, K30.7
                {10'b111010_1000, 8'hf7, 1'b1, 1'b0}, {10'b001001_0111, 8'hfb, 1'b1, 1'b0},
                {10'b101110_1000, 8'hfd, 1'b1, 1'b0}, {10'b100001_0111, 8'hfe, 1'b1, 1'b0},
                // Words outside the code
                {10'b000000_0000, 8'h00, 1'b1, 1'b0}, {10'b111111_1111, 8'h00, 1'b1, 1'b0},
                {10'b111100_1011, 8'h00, 1'b1, 1'b0}, {10'b101001_0111, 8'h00, 1'b1, 1'b0},
                {10'b100111_0000, 8'h00, 1'b1, 1'b0},
                // Balanced words flush the delay line before the monitor runs
                {FILLER, 8'hb5, 1'b0, 1'b0}, {FILLER, 8'hb5, 1'b0, 1'b0},
                {FILLER, 8'hb5, 1'b0, 1'b0}, {FILLER, 8'hb5, 1'b0, 1'b0},
                // Balanced stream with alternating K28.5 forms
                {K28_5_N, 8'hbc, 1'b1, 1'b1}, {10'b110000_0101, 8'hbc, 1'b1, 1'b1},
                {FILLER, 8'hb5, 1'b0, 1'b1}, {10'b101001_0110, 8'hc5, 1'b0, 1'b1},
                {K28_5_N, 8'hbc, 1'b1, 1'b1}, {10'b110000_0101, 8'hbc, 1'b1, 1'b1},
                {FILLER, 8'hb5, 1'b0, 1'b1}, {10'b101001_0110, 8'hc5, 1'b0, 1'b1},
                // Eight words of six ones each push the sum past 15
                {K28_5_N, 8'hbc, 1'b1, 1'b1}, {K28_5_N, 8'hbc, 1'b1, 1'b1},
                {K28_5_N, 8'hbc, 1'b1, 1'b1}, {K28_5_N, 8'hbc, 1'b1, 1'b1},
                {K28_5_N, 8'hbc, 1'b1, 1'b1}, {K28_5_N, 8'hbc, 1'b1, 1'b1},
                {K28_5_N, 8'hbc, 1'b1, 1'b1}, {K28_5_N, 8'hbc, 1'b1, 1'b1},
                // The RD+ form brings the sum back under 16 while the error holds
                {10'b110000_0101, 8'hbc, 1'b1, 1'b1}, {FILLER, 8'hb5, 1'b0, 1'b1},
                {FILLER, 8'hb5, 1'b0, 1'b1}, {FILLER, 8'hb5, 1'b0, 1'b1},
                {FILLER, 8'hb5, 1'b0, 1'b1}, {FILLER, 8'hb5, 1'b0, 1'b1},
                {FILLER, 8'hb5, 1'b0, 1'b1}, {FILLER, 8'hb5, 1'b0, 1'b1},
                // Autoneg low clears the error
                {FILLER, 8'hb5, 1'b0, 1'b0}, {FILLER, 8'hb5, 1'b0, 1'b0},
                {FILLER, 8'hb5, 1'b0, 1'b0}, {FILLER, 8'hb5, 1'b0, 1'b0}
        };

        sgmii_8b10b_decode
        #(
                .INPUT_STAGES   (INPUT_STAGES)
        )
        sgmii_8b10b_decode_inst
        (
                .clk                    (clk),
                .rst                    (rst),
                .sgmii_autoneg_start    (sgmii_autoneg_start),
                .ten_bit                (ten_bit),
                .eight_bit              (eight_bit),
                .is_k                   (is_k),
                .disp_err               (disp_err)
        );

        always #20 clk = ~clk;

        // --------------------
        // Compare tasks and model

        task automatic check_octet(input string name, input octet_t got, input octet_t exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
                end
        endtask

        task automatic check_bit(input string name, input logic got, input logic exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
                end
        endtask

        function automatic int count_ones(input code_group_t word);
                int n;
                n = 0;
                for (int i = 0; i < CODE_GROUP_W; i++)
                begin
                        n += word[i];
                end
                return n;
        endfunction

        // One falling edge: model the rising edge just passed, check, then drive
        task automatic tick(input code_group_t word, input octet_t oct, input logic k,
                            input logic an, input logic rst_v, input logic chk);
                flight_t done;
                flight_t entry;
                @(negedge clk);
                done = flight_q.pop_front();  // Also the word the sum just took
                if (prev_rst || !prev_an)
                begin
                        model_sum = RD_INIT;
                        model_err = 1'b0;
                end
                else
                begin
                        model_err = model_err | model_sum[RD_W-1];
                        model_sum = model_sum + rd_count_t'(count_ones(done.word)) - BALANCE_ONES;
                end
                if (done.chk)
                begin
                        check_octet("eight_bit", eight_bit, done.oct);
                        check_bit("is_k", is_k, done.k);
                end
                check_bit("disp_err", disp_err, model_err);
                if (model_err)
                begin
                        err_cycles++;
                end
                rst                 = rst_v;
                sgmii_autoneg_start = an;
                ten_bit             = word;
                entry.word = word;
                entry.oct  = oct;
                entry.k    = k;
                entry.chk  = chk;
                flight_q.push_back(entry);
                prev_an  = an;
                prev_rst = rst_v;
        endtask

        // --------------------
        // Main sequence

        initial
        begin
                flight_t fill;
                clk                 = 1'b0;
                rst                 = 1'b1;
                sgmii_autoneg_start = 1'b0;
                ten_bit             = FILLER;
                model_sum           = RD_INIT;
                model_err           = 1'b0;
                prev_an             = 1'b0;
                prev_rst            = 1'b1;
                fill.word = FILLER;
                fill.oct  = 8'h00;
                fill.k    = 1'b0;
                fill.chk  = 1'b0;
                for (int i = 0; i < LATENCY; i++)
                begin
                        flight_q.push_back(fill);
                end

                repeat (RESET_CYCLES) tick(FILLER, 8'hb5, 1'b0, 1'b0, 1'b1, 1'b0);
                for (int i = 0; i < NUM_ROWS; i++)
                begin
                        tick(stim[i].word, stim[i].oct, stim[i].k, stim[i].an, 1'b0, 1'b1);
                end

                // Set the error again, then reset with autoneg still high
                repeat (SET_CYCLES) tick(K28_5_N, 8'hbc, 1'b1, 1'b1, 1'b0, 1'b1);
                repeat (RESET_HOLD) tick(FILLER, 8'hb5, 1'b0, 1'b1, 1'b1, 1'b1);
                repeat (RELEASE) tick(FILLER, 8'hb5, 1'b0, 1'b1, 1'b0, 1'b1);

                if (err_cycles == 0)
                begin
                        errors++;
                        $display("The disparity error flag was never expected to rise");
                end

                assert_fails = sgmii_8b10b_decode_inst.running_disparity_monitor_inst
                               .sgmii_decode_asserts_inst.assert_failures;
                $display("Closing: %0d checks, %0d errors, %0d assertion failures",
                         checks, errors, assert_fails);
                if (errors == 0 && assert_fails == 0)
                begin
                        $display("Regression passed");
                end
                else
                begin
                        $display("Regression failed");
                end
                $finish;
        end

        initial
        begin
                while (cycle_count < TIMEOUT_CYCLES)
                begin
                        @(posedge clk);
                        cycle_count++;
                end
                $display("Timeout after %0d cycles before the tests finished", cycle_count);
                $display("Regression failed");
                $finish;
        end

endmodule

// ==== filelist.f ====
sgmii_pkg.sv
decode_6b5b.sv
decode_4b3b.sv
code_group_decoder.sv
running_disparity_monitor.sv
sgmii_8b10b_decode.sv
sgmii_decode_asserts.sv
sgmii_decode_tb.sv

// ==== Bender.yml ====
package:
  name: sgmii_8b10b_decode

sources:
  - sgmii_pkg.sv
  - decode_6b5b.sv
  - decode_4b3b.sv
  - code_group_decoder.sv
  - running_disparity_monitor.sv
  - sgmii_8b10b_decode.sv
  - target: test
    files:
      - sgmii_decode_asserts.sv
      - sgmii_decode_tb.sv
